// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f tb.f --top-module hacd_tb -o hacd_sim

sim_out="$(./obj_dir/hacd_sim)"
echo "${sim_out}"
grep -qx "Test passed" <<< "${sim_out}"

// File: tb.f
verilog/hacd_mem_pkg.sv
verilog/hacd_bus_pkg.sv
verilog/hacd_req_decode.sv
verilog/hacd_xlate_exec.sv
verilog/hacd_result.sv
verilog/hacd_core.sv
verification/hacd_props.sv
verification/hacd_checker.sv
verification/hacd_tb.sv

// File: verification/hacd_checker.sv
// response checker, compares each completed APB transfer with the vector file
`timescale 1ns/1ps

module hacd_checker (
   input  logic                   clk_i,
   input  logic                   arst_n,
   input  hacd_bus_pkg::apb_rsp_s apb_rsp,
   output int                     n_run,
   output int                     n_fail
);

   localparam string VEC_FILE = "verification/hacd_input.txt";

   logic        op_q    [$];
   logic [11:0] addr_q  [$];
   logic [31:0] rdata_q [$];
   logic        err_q   [$];

   task automatic load_expected();
      int          fd;
      string       line;
      logic        op;
      logic [11:0] addr;
      logic [31:0] wdata;
      logic [31:0] exp_rdata;
      logic        exp_err;
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         $display("checker cannot open %s", VEC_FILE);
         return;
      end
      while ($fgets(line, fd) > 0) begin
         if (line.substr(0, 0) != "#" &&
             $sscanf(line, "%h %h %h %h %h", op, addr, wdata, exp_rdata, exp_err) == 5) begin
            op_q.push_back(op);
            addr_q.push_back(addr);
            rdata_q.push_back(exp_rdata);
            err_q.push_back(exp_err);
         end
      end
      $fclose(fd);
   endtask

   initial begin
      n_run  = 0;
      n_fail = 0;
      load_expected();
   end

   ////////////////////////////////////////////////////////////
   // compare on the cycle pready is high
   ////////////////////////////////////////////////////////////
   task automatic check_transfer();
      bit bad;
      bad = 1'b0;
      if (n_run >= op_q.size()) begin
         $display("test %0d: pready seen with no transfer left in the list", n_run);
         bad = 1'b1;
      end else begin
         // prdata only means something on reads
         if (!op_q[n_run] && apb_rsp.prdata !== rdata_q[n_run]) begin
            $display("Mismatch test %0d addr %h: prdata expected %h got %h",
                     n_run, addr_q[n_run], rdata_q[n_run], apb_rsp.prdata);
            bad = 1'b1;
         end
         if (apb_rsp.pslverr !== err_q[n_run]) begin
            $display("Mismatch test %0d addr %h: pslverr expected %h got %h",
                     n_run, addr_q[n_run], err_q[n_run], apb_rsp.pslverr);
            bad = 1'b1;
         end
         if (!bad) begin
            $display("test %0d ok: %s addr %h", n_run, op_q[n_run] ? "write" : "read",
                     addr_q[n_run]);
         end
      end
      if (bad) begin
         n_fail = n_fail + 1;
      end
      n_run = n_run + 1;
   endtask

   always @(negedge clk_i) begin
      if (arst_n && apb_rsp.pready) begin
         check_transfer();
      end
   end

endmodule

// File: verification/hacd_input.txt
# op (0 read, 1 write)  paddr  wdata  expected prdata  expected pslverr, all hex
# paddr bits 8:5 select the page, bits 4:2 the word
0 074 00000000 00000000 0
0 1fc 00000000 00000000 0
1 028 00000000 00000000 0
0 028 00000000 00000000 0
1 00c 11111111 00000000 0
0 00c 00000000 11111111 0
0 000 00000000 00000000 0
0 01c 00000000 00000000 0
1 000 a5a5a5a5 00000000 0
0 000 00000000 a5a5a5a5 0
0 60c 00000000 11111111 0
1 044 22222222 00000000 0
0 044 00000000 22222222 0
0 004 00000000 00000000 0
1 028 01010101 00000000 0
0 028 00000000 01010101 0
0 020 00000000 00000000 0
1 07c 33333333 00000000 0
1 080 44444444 00000000 0
1 0b0 55555555 00000000 0
1 0c8 66666666 00000000 0
1 0e4 77777777 00000000 0
1 124 99999999 00000000 1
0 124 00000000 00000000 0
0 100 00000000 00000000 0
0 07c 00000000 33333333 0
0 0e4 00000000 77777777 0
0 0b0 00000000 55555555 0
1 0cc 00000000 00000000 0
0 0cc 00000000 00000000 0
0 0c8 00000000 66666666 0
1 1e0 00000000 00000000 0
0 1e0 00000000 00000000 0
0 00c 00000000 11111111 0

// File: verification/hacd_props.sv
// concurrent APB handshake assertions, bound into the core
`timescale 1ns/1ps

module hacd_props (
   input logic                   clk_i,
   input logic                   arst_n,
   input hacd_bus_pkg::apb_req_s apb_req,
   input hacd_bus_pkg::apb_rsp_s apb_rsp
);

   // pready only answers an access phase
   ready_in_access: assert property (@(posedge clk_i) disable iff (!arst_n)
      apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
      else $error("pready raised outside the APB access phase");

   // error flag is only meaningful with pready
   err_with_ready: assert property (@(posedge clk_i) disable iff (!arst_n)
      apb_rsp.pslverr |-> apb_rsp.pready)
      else $error("pslverr raised without pready");

   // single cycle completion pulse
   ready_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n)
      apb_rsp.pready |=> !apb_rsp.pready)
      else $error("pready held high for two cycles");

endmodule

bind hacd_core hacd_props u_props (
   .clk_i   (clk_i),
   .arst_n  (arst_n),
   .apb_req (apb_req),
   .apb_rsp (apb_rsp)
);

// File: verification/hacd_tb.sv
// testbench top with clock, reset, file driven APB master and cycle limit
`timescale 1ns/1ps

module hacd_tb;

   localparam string VEC_FILE        = "verification/hacd_input.txt";
   localparam int    CYCLES_PER_TEST = 15;
   localparam int    CYCLE_SLACK     = 50;

   logic                   clk_i;
   logic                   arst_n;
   hacd_bus_pkg::apb_req_s apb_req;
   hacd_bus_pkg::apb_rsp_s apb_rsp;
   int                     n_run;
   int                     n_fail;
   int                     n_vec;
   int                     cycles = 0;
   int                     cycle_limit = 0;

   logic        op_q    [$];
   logic [11:0] addr_q  [$];
   logic [31:0] wdata_q [$];

   hacd_core DUT (
      .clk_i   (clk_i),
      .arst_n  (arst_n),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp)
   );

   hacd_checker u_checker (
      .clk_i   (clk_i),
      .arst_n  (arst_n),
      .apb_rsp (apb_rsp),
      .n_run   (n_run),
      .n_fail  (n_fail)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // run limit grows with the number of transfers in the file
   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("run timed out after %0d cycles", cycles);
         $display("Test failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////
   task automatic load_vectors();
      int          fd;
      string       line;
      logic        op;
      logic [11:0] addr;
      logic [31:0] wdata;
      logic [31:0] exp_rdata;
      logic        exp_err;
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         $display("cannot open stimulus file %s", VEC_FILE);
         return;
      end
      while ($fgets(line, fd) > 0) begin
         if (line.substr(0, 0) != "#" &&
             $sscanf(line, "%h %h %h %h %h", op, addr, wdata, exp_rdata, exp_err) == 5) begin
            op_q.push_back(op);
            addr_q.push_back(addr);
            wdata_q.push_back(wdata);
         end
      end
      $fclose(fd);
   endtask

   // one APB transfer, setup then access until pready
   task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                               input logic [31:0] wdata);
      @(negedge clk_i);
      apb_req.paddr   = addr;
      apb_req.pwrite  = wr;
      apb_req.pwdata  = wdata;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      @(negedge clk_i);
      apb_req.penable = 1'b1;
      do @(negedge clk_i); while (!apb_rsp.pready);
      // transfer completes on the next rising edge
      @(negedge clk_i);
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   initial begin
      apb_req = '0;
      arst_n  = 1'b0;
      load_vectors();
      n_vec       = op_q.size();
      cycle_limit = n_vec * CYCLES_PER_TEST + CYCLE_SLACK;
      repeat (4) @(negedge clk_i);
      arst_n = 1'b1;
      for (int i = 0; i < n_vec; i++) begin
         apb_transfer(op_q[i], addr_q[i], wdata_q[i]);
      end
      repeat (3) @(negedge clk_i);
      if (n_run != n_vec) begin
         $display("%0d transfers listed but %0d completed", n_vec, n_run);
      end
      $display("%0d tests run, %0d passed, %0d failed", n_run, n_run - n_fail, n_fail);
      if (n_vec > 0 && n_run == n_vec && n_fail == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: verilog/hacd_bus_pkg.sv
// APB and internal request/response packet structs
package hacd_bus_pkg;

   localparam int ADDR_W  = 12;
   // byte offset inside a 32 bit word
   localparam int BYTE_OFS_W = 2;

   ////////////////////////////////////////////////////////////
   // APB slave side
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [ADDR_W-1:0]                paddr;
      logic                             pwrite;
      logic [hacd_mem_pkg::DATA_W-1:0]  pwdata;
      logic                             psel;
      logic                             penable;
   } apb_req_s;

   typedef struct packed {
      logic [hacd_mem_pkg::DATA_W-1:0] prdata;
      logic                            pready;
      logic                            pslverr;
   } apb_rsp_s;

   ////////////////////////////////////////////////////////////
   // decode to execute, execute to result
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic                             valid;
      logic                             write;
      logic [hacd_mem_pkg::PAGE_W-1:0]  page;
      logic [hacd_mem_pkg::OFS_W-1:0]   offset;
      logic [hacd_mem_pkg::DATA_W-1:0]  wdata;
   } hacd_req_s;

   typedef struct packed {
      logic                             valid;
      logic                             write;
      logic                             is_mapped;
      logic [hacd_mem_pkg::FRAME_W-1:0] frame;
      logic [hacd_mem_pkg::OFS_W-1:0]   offset;
      logic [hacd_mem_pkg::DATA_W-1:0]  wdata;
      logic                             fill;
      logic                             err;
   } hacd_exe_s;

endpackage

// File: verilog/hacd_core.sv
// compressor front end top level, decode to execute to result
`timescale 1ns/1ps

module hacd_core (
   input  logic                   clk_i,
   input  logic                   arst_n,
   input  hacd_bus_pkg::apb_req_s apb_req,
   output hacd_bus_pkg::apb_rsp_s apb_rsp
);

   hacd_bus_pkg::hacd_req_s req;
   hacd_bus_pkg::hacd_exe_s exe;
   logic                    done;

   ////////////////////////////////////////////////////////////
   // request path
   ////////////////////////////////////////////////////////////
   hacd_req_decode u_req_decode (
      .clk_i   (clk_i),
      .arst_n  (arst_n),
      .apb_req (apb_req),
      .done    (done),
      .req     (req)
   );

   // translation and decompress
   hacd_xlate_exec u_xlate_exec (
      .clk_i  (clk_i),
      .arst_n (arst_n),
      .req    (req),
      .exe    (exe)
   );

   // memory and APB response
   hacd_result u_result (
      .clk_i   (clk_i),
      .arst_n  (arst_n),
      .exe     (exe),
      .apb_rsp (apb_rsp),
      .done    (done)
   );

endmodule

// File: verilog/hacd_mem_pkg.sv
// page, frame and translation table entry definitions
package hacd_mem_pkg;

   ////////////////////////////////////////////////////////////
   // memory geometry
   ////////////////////////////////////////////////////////////
   localparam int DATA_W         = 32;
   localparam int NUM_PAGES      = 16;
   localparam int PAGE_W         = 4;
   localparam int WORDS_PER_PAGE = 8;
   localparam int OFS_W          = 3;
   localparam int NUM_FRAMES     = 8;
   localparam int FRAME_W        = 3;
   localparam int MEM_DEPTH      = NUM_FRAMES * WORDS_PER_PAGE;

   ////////////////////////////////////////////////////////////
   // ATT entry, two views of one word
   ////////////////////////////////////////////////////////////
   // uncompressed page, backed by a frame
   typedef struct packed {
      logic               dirty;
      logic [FRAME_W-1:0] frame;
   } uncomp_entry_s;

   // zero page, no frame behind it
   typedef struct packed {
      logic       zwr;
      logic [2:0] rsvd;
   } zero_entry_s;

   typedef union packed {
      uncomp_entry_s uncomp;
      zero_entry_s   zero;
   } att_entry_u;

   // lookup result
   typedef struct packed {
      logic       is_mapped;
      att_entry_u entry;
   } att_entry_t;

endpackage

// File: verilog/hacd_req_decode.sv
// APB slave front end, address split and request issue
`timescale 1ns/1ps

module hacd_req_decode (
   input  logic                    clk_i,
   input  logic                    arst_n,
   input  hacd_bus_pkg::apb_req_s  apb_req,
   input  logic                    done,
   output hacd_bus_pkg::hacd_req_s req
);

   localparam int OFS_LSB  = hacd_bus_pkg::BYTE_OFS_W;
   localparam int PAGE_LSB = OFS_LSB + hacd_mem_pkg::OFS_W;

   logic access;
   logic acc_q;
   logic busy_q;
   logic issue;
   hacd_bus_pkg::hacd_req_s req_q;

   // access phase, psel and penable both high
   assign access = apb_req.psel && apb_req.penable;

   // first cycle of the access phase only, and never while a
   // request is still being worked on
   assign issue = access && !acc_q && !busy_q;

   always_ff @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
         acc_q  <= 1'b0;
         busy_q <= 1'b0;
      end else begin
         acc_q <= access;
         if (issue) begin
            busy_q <= 1'b1;
         end else if (done) begin
            busy_q <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // request packet
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
         req_q <= '0;
      end else begin
         req_q.valid <= issue;
         if (issue) begin
            req_q.write  <= apb_req.pwrite;
            // word address, upper paddr bits ignored
            req_q.page   <= apb_req.paddr[PAGE_LSB +: hacd_mem_pkg::PAGE_W];
            req_q.offset <= apb_req.paddr[OFS_LSB +: hacd_mem_pkg::OFS_W];
            req_q.wdata  <= apb_req.pwdata;
         end
      end
   end

   assign req = req_q;

endmodule

// File: verilog/hacd_result.sv
// frame memory, read data select and APB completion
`timescale 1ns/1ps

module hacd_result (
   input  logic                    clk_i,
   input  logic                    arst_n,
   input  hacd_bus_pkg::hacd_exe_s exe,
   output hacd_bus_pkg::apb_rsp_s  apb_rsp,
   output logic                    done
);

   localparam int ADDR_W = hacd_mem_pkg::FRAME_W + hacd_mem_pkg::OFS_W;

   logic [hacd_mem_pkg::DATA_W-1:0] mem [hacd_mem_pkg::MEM_DEPTH];
   logic [ADDR_W-1:0]               addr;
   logic                            mem_we;
   logic                            last_beat;
   logic [hacd_mem_pkg::DATA_W-1:0] rdata_q;
   logic                            ready_q;
   logic                            err_q;

   // frame base plus word offset
   assign addr = {exe.frame, exe.offset};

   // fill beats and real writes to a mapped page
   assign mem_we = exe.valid && exe.write && exe.is_mapped && !exe.err;

   // every beat but a fill beat closes the transfer
   assign last_beat = exe.valid && !exe.fill;

   ////////////////////////////////////////////////////////////
   // frame memory
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (mem_we) begin
         mem[addr] <= exe.wdata;
      end
      // zero pages read as 0 without touching a frame
      if (exe.is_mapped && !exe.write) begin
         rdata_q <= mem[addr];
      end else begin
         rdata_q <= '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // completion
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
         ready_q <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         ready_q <= last_beat;
         err_q   <= exe.err;
      end
   end

   assign apb_rsp.prdata  = rdata_q;
   assign apb_rsp.pready  = ready_q;
   assign apb_rsp.pslverr = err_q;

   // decode may take the next transfer
   assign done = ready_q;

endmodule

// File: verilog/hacd_xlate_exec.sv
// ATT lookup, frame allocator and zero-fill FSM
`timescale 1ns/1ps

module hacd_xlate_exec (
   input  logic                    clk_i,
   input  logic                    arst_n,
   input  hacd_bus_pkg::hacd_req_s req,
   output hacd_bus_pkg::hacd_exe_s exe
);

   typedef enum logic {
      ST_IDLE,
      ST_FILL
   } state_e;

   state_e                                state_q;
   logic [hacd_mem_pkg::OFS_W-1:0]        fill_cnt_q;
   hacd_bus_pkg::hacd_req_s               hold_q;
   hacd_mem_pkg::att_entry_u              att_q [hacd_mem_pkg::NUM_PAGES];
   logic [hacd_mem_pkg::NUM_PAGES-1:0]    att_valid_q;
   logic [hacd_mem_pkg::FRAME_W:0]        frames_used_q;
   hacd_mem_pkg::att_entry_t              lkup;
   hacd_bus_pkg::hacd_exe_s               exe_d;
   hacd_bus_pkg::hacd_exe_s               exe_q;
   logic                                  frames_full;
   logic                                  wr_nz;
   logic                                  alloc;

   // lookup, valid bit picks the uncompressed view
   assign lkup.is_mapped = att_valid_q[req.page];
   assign lkup.entry     = att_q[req.page];

   assign frames_full = frames_used_q == (hacd_mem_pkg::FRAME_W+1)'(hacd_mem_pkg::NUM_FRAMES);
   assign wr_nz       = req.write && (req.wdata != '0);
   assign alloc       = req.valid && !lkup.is_mapped && wr_nz && !frames_full;

   ////////////////////////////////////////////////////////////
   // next beat
   ////////////////////////////////////////////////////////////
   always_comb begin
      exe_d = '0;
      if (state_q == ST_FILL) begin
         exe_d.valid     = 1'b1;
         exe_d.write     = 1'b1;
         exe_d.is_mapped = 1'b1;
         exe_d.frame     = att_q[hold_q.page].uncomp.frame;
         if (fill_cnt_q != '0) begin
            exe_d.fill   = 1'b1;
            exe_d.offset = fill_cnt_q;
         end else begin
            // fill wrapped, now the write that started it
            exe_d.offset = hold_q.offset;
            exe_d.wdata  = hold_q.wdata;
         end
      end else if (alloc) begin
         // fill beat for word 0 of the new frame
         exe_d.valid     = 1'b1;
         exe_d.write     = 1'b1;
         exe_d.is_mapped = 1'b1;
         exe_d.fill      = 1'b1;
         exe_d.frame     = frames_used_q[hacd_mem_pkg::FRAME_W-1:0];
      end else if (req.valid) begin
         exe_d.valid     = 1'b1;
         exe_d.write     = req.write;
         exe_d.is_mapped = lkup.is_mapped;
         exe_d.frame     = lkup.entry.uncomp.frame;
         exe_d.offset    = req.offset;
         exe_d.wdata     = req.wdata;
         exe_d.err       = !lkup.is_mapped && wr_nz && frames_full;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
         state_q       <= ST_IDLE;
         fill_cnt_q    <= '0;
         hold_q        <= '0;
         att_valid_q   <= '0;
         frames_used_q <= '0;
         exe_q         <= '0;
         for (int i = 0; i < hacd_mem_pkg::NUM_PAGES; i++) begin
            att_q[i] <= '0;
         end
      end else begin
         exe_q <= exe_d;
         if (state_q == ST_FILL) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
            if (fill_cnt_q == '0) begin
               state_q <= ST_IDLE;
            end
         end else if (alloc) begin
            // decompress, page takes the next free frame
            state_q                      <= ST_FILL;
            fill_cnt_q                   <= 1;
            hold_q                       <= req;
            att_valid_q[req.page]        <= 1'b1;
            att_q[req.page].uncomp.frame <= frames_used_q[hacd_mem_pkg::FRAME_W-1:0];
            frames_used_q                <= frames_used_q + 1'b1;
         end
      end
   end

   assign exe = exe_q;

endmodule
